/* include/osd_consts.svh */
/*
 Protocol constants for the register access front end.
 Include wherever type codes, register map limits or the
 flit position limit are needed.
*/
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// Packet type code of register access traffic
`define OSD_TYPE_REG 2'd0

// Register map, addresses 0 to 7
`define OSD_REG_COUNT 8

// Read-only identification register
`define OSD_REG_ID_ADDR 16'd0
`define OSD_REG_ID_VALUE 16'h0A51

// Flit position limit of the request counter
`define OSD_MAX_FLITS 3'd7

`endif

/* hdl/osd_pkg.sv */
/*
 Shared types for the debug interconnect register access front end.
 Holds the link flit, the two views of a header word and the
 register access subtype codes. Import it where these types are used.
*/
package osd_pkg;

   // One link beat toward the receiver
   typedef struct packed {
      logic [15:0] data;
      logic        last;
      logic        valid;
   } dii_flit;

   // Field layout of the flags flit, type in the top two bits
   typedef struct packed {
      logic [1:0] pkt_type;
      logic [3:0] type_sub;
      logic [9:0] reserved;
   } dii_flags;

   // A data word seen either raw or as flags
   typedef union packed {
      logic [15:0] raw;
      dii_flags    flags;
   } dii_word;

   // Register access subtypes, requests and responses
   typedef enum logic [3:0] {
      REQ_READ_16    = 4'd0,
      REQ_WRITE_16   = 4'd2,
      RESP_READ_OK   = 4'd8,
      RESP_READ_ERR  = 4'd9,
      RESP_WRITE_OK  = 4'd10,
      RESP_WRITE_ERR = 4'd11
   } regacc_sub;

endpackage

/* hdl/osd_reg_file.sv */
/*
 Register map of the debug module. Address 0 reads the fixed identification
 value and refuses writes, addresses 1 to 7 are scratch registers.
 Read data and the error flag are combinational on addr and we.
*/
`timescale 1ns/10ps
`include "osd_consts.svh"

module osd_reg_file (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] addr,
   input  logic [15:0] wdata,
   input  logic        we,
   output logic [15:0] rdata,
   output logic        err
);

   logic [15:0] regs [1:`OSD_REG_COUNT-1];
   logic        in_range;
   logic        is_id;

   assign in_range = (addr < `OSD_REG_COUNT);
   assign is_id    = (addr == `OSD_REG_ID_ADDR);
   assign err      = ~in_range | (we & is_id);

   always_comb begin
      if (is_id) begin
         rdata = `OSD_REG_ID_VALUE;
      end else if (in_range) begin
         rdata = regs[addr[2:0]];
      end else begin
         rdata = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `OSD_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we && !err) begin
         regs[addr[2:0]] <= wdata;
      end
   end

endmodule

/* hdl/osd_flit_counter.sv */
/*
 Flit position counter for the request handler.
 Counts accepted flits within a packet and stops at the position limit,
 so payload beyond the header never aliases onto header positions.
*/
`timescale 1ns/10ps
`include "osd_consts.svh"

module osd_flit_counter (
   input  logic       clk,
   input  logic       rst,
   input  logic       clear,
   input  logic       inc,
   output logic [2:0] value
);

   always_ff @(posedge clk) begin
      if (rst) begin
         value <= '0;
      end else if (clear) begin
         // Packet boundary wins over a same-cycle increment
         value <= '0;
      end else if (inc && value != `OSD_MAX_FLITS) begin
         value <= value + 3'd1;
      end
   end

endmodule

/* hdl/osd_regaccess_demux.sv */
/*
 Splits the incoming link by packet type. Three flits are buffered so the
 flags flit can be decoded before the destination flit leaves; register
 access packets go to out_reg, everything else to out_bypass.
 Packets must carry at least the destination, source and flags flits.
*/
`timescale 1ns/10ps
`include "osd_consts.svh"

module osd_regaccess_demux
   import osd_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  dii_flit in,
   output logic    in_ready,
   output dii_flit out_reg,
   input  logic    out_reg_ready,
   output dii_flit out_bypass,
   input  logic    out_bypass_ready
);

   // Stage 0 takes new flits, stage 2 is the output head
   dii_flit    buf_q [3];
   logic [2:0] tag_q;
   logic [2:0] reg_q;

   dii_word    flags_word;
   logic       tag_is_reg;
   logic       do_tag;
   logic [2:0] tag_e;
   logic [2:0] reg_e;

   logic       pop;
   logic       mv2;
   logic       mv1;
   logic       accept;

   // Packet tagged, rest of it still arriving
   logic       cur_active;
   logic       cur_reg;
   logic       act;
   logic       act_reg;

   always_comb begin
      flags_word.raw = buf_q[0].data;
      tag_is_reg = (flags_word.flags.pkt_type == `OSD_TYPE_REG);
      // Dest, src and flags all buffered and not yet classified
      do_tag = buf_q[0].valid & buf_q[1].valid & buf_q[2].valid & ~tag_q[2];
      for (int i = 0; i < 3; i++) begin
         tag_e[i] = tag_q[i] | do_tag;
         reg_e[i] = tag_q[i] ? reg_q[i] : tag_is_reg;
      end
   end

   assign out_reg.data     = buf_q[2].data;
   assign out_reg.last     = buf_q[2].last;
   assign out_reg.valid    = buf_q[2].valid & tag_e[2] & reg_e[2];

   assign out_bypass.data  = buf_q[2].data;
   assign out_bypass.last  = buf_q[2].last;
   assign out_bypass.valid = buf_q[2].valid & tag_e[2] & ~reg_e[2];

   // Buffer compacts toward the head whenever a slot frees up
   assign pop      = (out_reg.valid & out_reg_ready) | (out_bypass.valid & out_bypass_ready);
   assign mv2      = ~buf_q[2].valid | pop;
   assign mv1      = ~buf_q[1].valid | mv2;
   assign in_ready = ~buf_q[0].valid | mv1;
   assign accept   = in.valid & in_ready;

   // Flits behind the flags flit inherit its classification
   assign act     = cur_active | (do_tag & ~buf_q[0].last);
   assign act_reg = cur_active ? cur_reg : tag_is_reg;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 3; i++) begin
            buf_q[i].valid <= 1'b0;
         end
         tag_q      <= '0;
         reg_q      <= '0;
         cur_active <= 1'b0;
         cur_reg    <= 1'b0;
      end else begin
         if (mv2) begin
            buf_q[2] <= buf_q[1];
            tag_q[2] <= tag_e[1];
            reg_q[2] <= reg_e[1];
         end else begin
            tag_q[2] <= tag_e[2];
            reg_q[2] <= reg_e[2];
         end

         if (mv1) begin
            buf_q[1] <= buf_q[0];
            tag_q[1] <= tag_e[0];
            reg_q[1] <= reg_e[0];
         end else begin
            tag_q[1] <= tag_e[1];
            reg_q[1] <= reg_e[1];
         end

         if (in_ready) begin
            buf_q[0]       <= in;
            buf_q[0].valid <= accept;
            tag_q[0]       <= accept & act;
            reg_q[0]       <= act_reg;
         end else begin
            tag_q[0] <= tag_e[0];
            reg_q[0] <= reg_e[0];
         end

         // Ends once the last flit of the tagged packet is taken in
         cur_active <= act & ~(accept & in.last);
         cur_reg    <= act_reg;
      end
   end

endmodule

/* hdl/osd_regaccess_fsm.sv */
/*
 Register access request handler. Parses a request packet by flit position,
 performs one 16-bit read or write on the register file and sends back the
 response packet. Unknown or truncated requests are consumed silently.
*/
`timescale 1ns/10ps
`include "osd_consts.svh"

module osd_regaccess_fsm
   import osd_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] module_id,
   input  dii_flit     req,
   output logic        req_ready,
   output dii_flit     resp,
   input  logic        resp_ready,
   output logic        cnt_clear,
   output logic        cnt_inc,
   input  logic [2:0]  cnt_value,
   output logic [15:0] reg_addr,
   output logic [15:0] reg_wdata,
   output logic        reg_we,
   input  logic [15:0] reg_rdata,
   input  logic        reg_err
);

   typedef enum logic [1:0] {
      RECV,
      EXEC,
      SEND,
      DROP
   } state_t;

   state_t      state_q;
   state_t      state_d;

   // Captured request fields
   logic [15:0] src_q;
   regacc_sub   sub_q;
   logic [15:0] addr_q;
   logic [15:0] wdata_q;

   // Access result
   logic [15:0] rdata_q;
   logic        err_q;

   dii_word     in_word;
   dii_word     resp_flags;
   regacc_sub   sub_now;
   regacc_sub   resp_sub;
   logic        known_sub;
   logic        fields_ok;
   logic        has_data;
   logic        resp_last;

   assign reg_addr  = addr_q;
   assign reg_wdata = wdata_q;

   always_comb begin
      in_word.raw = req.data;
      // Flags flit in flight, its subtype is not captured yet
      sub_now = (cnt_value == 3'd2) ? regacc_sub'(in_word.flags.type_sub) : sub_q;
      known_sub = (sub_now == REQ_READ_16) | (sub_now == REQ_WRITE_16);
      fields_ok = ((sub_now == REQ_READ_16) & (cnt_value >= 3'd3))
         | ((sub_now == REQ_WRITE_16) & (cnt_value >= 3'd4));

      if (sub_q == REQ_WRITE_16) begin
         resp_sub = err_q ? RESP_WRITE_ERR : RESP_WRITE_OK;
      end else begin
         resp_sub = err_q ? RESP_READ_ERR : RESP_READ_OK;
      end
      resp_flags.flags.pkt_type = `OSD_TYPE_REG;
      resp_flags.flags.type_sub = resp_sub;
      resp_flags.flags.reserved = '0;

      has_data  = (sub_q == REQ_READ_16) & ~err_q;
      resp_last = has_data ? (cnt_value == 3'd3) : (cnt_value == 3'd2);
   end

   always_comb begin
      state_d   = state_q;
      req_ready = 1'b0;
      resp      = '0;
      cnt_clear = 1'b0;
      cnt_inc   = 1'b0;
      reg_we    = 1'b0;
      case (state_q)
         RECV: begin
            req_ready = 1'b1;
            if (req.valid) begin
               cnt_inc = 1'b1;
               if (req.last) begin
                  cnt_clear = 1'b1;
                  if (fields_ok) begin
                     state_d = EXEC;
                  end
               end else if (cnt_value == 3'd2 && !known_sub) begin
                  state_d = DROP;
               end
            end
         end
         EXEC: begin
            // Write request, the register file refuses protected addresses
            reg_we    = (sub_q == REQ_WRITE_16);
            cnt_clear = 1'b1;
            state_d   = SEND;
         end
         SEND: begin
            resp.valid = 1'b1;
            resp.last  = resp_last;
            case (cnt_value)
               3'd0:    resp.data = src_q;
               3'd1:    resp.data = module_id;
               3'd2:    resp.data = resp_flags.raw;
               default: resp.data = rdata_q;
            endcase
            if (resp_ready) begin
               cnt_inc = 1'b1;
               if (resp_last) begin
                  cnt_clear = 1'b1;
                  state_d   = RECV;
               end
            end
         end
         DROP: begin
            req_ready = 1'b1;
            if (req.valid && req.last) begin
               cnt_clear = 1'b1;
               state_d   = RECV;
            end
         end
         default: state_d = RECV;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= RECV;
      end else begin
         state_q <= state_d;
      end
   end

   // Field capture by position, dest flit is not needed
   always_ff @(posedge clk) begin
      if (state_q == RECV && req.valid) begin
         case (cnt_value)
            3'd1:    src_q <= req.data;
            3'd2:    sub_q <= regacc_sub'(in_word.flags.type_sub);
            3'd3:    addr_q <= req.data;
            3'd4:    wdata_q <= req.data;
            default: ;
         endcase
      end
      if (state_q == EXEC) begin
         rdata_q <= reg_rdata;
         err_q   <= reg_err;
      end
   end

endmodule

/* hdl/osd_out_arbiter.sv */
/*
 Merges the response and bypass links onto the outgoing link.
 A packet keeps the link from its first presented flit to its last transfer;
 the response side wins the first contest, later contests alternate.
*/
`timescale 1ns/10ps

module osd_out_arbiter
   import osd_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  dii_flit resp,
   output logic    resp_ready,
   input  dii_flit bypass,
   output logic    bypass_ready,
   output dii_flit out,
   input  logic    out_ready
);

   logic locked_q;
   logic sel_q;
   logic prio_byp_q;
   logic grant_byp;
   logic sel;

   always_comb begin
      if (resp.valid && bypass.valid) begin
         grant_byp = prio_byp_q;
      end else begin
         grant_byp = bypass.valid;
      end
      // High selects bypass
      sel          = locked_q ? sel_q : grant_byp;
      out          = sel ? bypass : resp;
      resp_ready   = out_ready & ~sel;
      bypass_ready = out_ready & sel;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         locked_q   <= 1'b0;
         sel_q      <= 1'b0;
         prio_byp_q <= 1'b0;
      end else if (out.valid) begin
         locked_q <= ~(out_ready & out.last);
         sel_q    <= sel;
         if (!locked_q) begin
            prio_byp_q <= ~sel;
         end
      end
   end

endmodule

/* hdl/osd_regaccess_top.sv */
/*
 Register access front end of one debug module.
 Incoming packets are split by type; register requests are answered from
 the local register file, and responses and bypass traffic share out_link.
*/
`timescale 1ns/10ps

module osd_regaccess_top
   import osd_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] module_id,
   input  dii_flit     in_link,
   output logic        in_ready,
   output dii_flit     out_link,
   input  logic        out_ready
);

   dii_flit     reg_link;
   dii_flit     bypass_link;
   dii_flit     resp_link;
   logic        reg_ready;
   logic        bypass_ready;
   logic        resp_ready;

   logic        cnt_clear;
   logic        cnt_inc;
   logic [2:0]  cnt_value;

   logic [15:0] reg_addr;
   logic [15:0] reg_wdata;
   logic        reg_we;
   logic [15:0] reg_rdata;
   logic        reg_err;

   osd_regaccess_demux u_demux (
      .clk              (clk),
      .rst              (rst),
      .in               (in_link),
      .in_ready         (in_ready),
      .out_reg          (reg_link),
      .out_reg_ready    (reg_ready),
      .out_bypass       (bypass_link),
      .out_bypass_ready (bypass_ready)
   );

   osd_regaccess_fsm u_fsm (
      .clk        (clk),
      .rst        (rst),
      .module_id  (module_id),
      .req        (reg_link),
      .req_ready  (reg_ready),
      .resp       (resp_link),
      .resp_ready (resp_ready),
      .cnt_clear  (cnt_clear),
      .cnt_inc    (cnt_inc),
      .cnt_value  (cnt_value),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_we     (reg_we),
      .reg_rdata  (reg_rdata),
      .reg_err    (reg_err)
   );

   osd_flit_counter u_cnt (
      .clk   (clk),
      .rst   (rst),
      .clear (cnt_clear),
      .inc   (cnt_inc),
      .value (cnt_value)
   );

   osd_reg_file u_regs (
      .clk   (clk),
      .rst   (rst),
      .addr  (reg_addr),
      .wdata (reg_wdata),
      .we    (reg_we),
      .rdata (reg_rdata),
      .err   (reg_err)
   );

   osd_out_arbiter u_arb (
      .clk          (clk),
      .rst          (rst),
      .resp         (resp_link),
      .resp_ready   (resp_ready),
      .bypass       (bypass_link),
      .bypass_ready (bypass_ready),
      .out          (out_link),
      .out_ready    (out_ready)
   );

endmodule

/* testbench/osd_regaccess_props.sv */
/*
 Concurrent checks on link handshakes and on register write-back.
 Bound into the output arbiter, the demux and the register file.
 Ports that do not apply to an instance are tied off in its bind.
*/
`timescale 1ns/10ps

module osd_regaccess_props
   import osd_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input dii_flit     link,
   input logic        link_ready,
   input logic        sel,
   input logic        we,
   input logic        err,
   input logic [15:0] addr,
   input logic [15:0] wdata,
   input logic [15:0] rdata
);

   // A presented flit waits unchanged for its transfer
   link_hold: assert property (@(posedge clk) disable iff (rst)
      link.valid && !link_ready |=> link.valid && $stable(link.data) && $stable(link.last))
      else $error("link flit changed before it was taken");

   // Selected input holds until the last flit has gone
   sel_hold: assert property (@(posedge clk) disable iff (rst)
      link.valid && !(link_ready && link.last) |=> $stable(sel))
      else $error("selected input switched inside a packet");

   // An accepted write is stored and reads back at the same address
   write_readback: assert property (@(posedge clk) disable iff (rst)
      we && !err |=> (addr != $past(addr)) || (rdata == $past(wdata)))
      else $error("written value did not read back from its register");

endmodule

bind osd_out_arbiter osd_regaccess_props u_arb_props (
   .clk        (clk),
   .rst        (rst),
   .link       (out),
   .link_ready (out_ready),
   .sel        (sel),
   .we         (1'b0),
   .err        (1'b0),
   .addr       (16'd0),
   .wdata      (16'd0),
   .rdata      (16'd0)
);

bind osd_regaccess_demux osd_regaccess_props u_demux_props (
   .clk        (clk),
   .rst        (rst),
   .link       (out_bypass),
   .link_ready (out_bypass_ready),
   .sel        (1'b0),
   .we         (1'b0),
   .err        (1'b0),
   .addr       (16'd0),
   .wdata      (16'd0),
   .rdata      (16'd0)
);

bind osd_reg_file osd_regaccess_props u_regs_props (
   .clk        (clk),
   .rst        (rst),
   .link       ('0),
   .link_ready (1'b0),
   .sel        (1'b0),
   .we         (we),
   .err        (err),
   .addr       (addr),
   .wdata      (wdata),
   .rdata      (rdata)
);

/* testbench/osd_regaccess_tb.sv */
/*
 Trace driven testbench for the register access front end.
 Stimulus and expected packets come from testbench/osd_regaccess_trace.txt.
 out_ready is stalled at random, and each output packet is matched against
 the expected list of its stream, which the source flit identifies.
*/
`timescale 1ns/10ps

module osd_regaccess_tb
   import osd_pkg::*;
();

   localparam logic [15:0] MODULE_ID = 16'h0005;

   logic    clk;
   logic    rst;
   dii_flit in_link;
   logic    in_ready;
   dii_flit out_link;
   logic    out_ready;

   // Trace contents, expected packets split by stream
   dii_flit     stim_q[$];
   dii_flit     exp_resp_q[$];
   dii_flit     exp_byp_q[$];
   int          n_flits = 0;
   int          limit;
   int          cycles;

   // Monitor state inside the current output packet
   int          out_pos = 0;
   logic        to_resp = 1'b0;
   dii_flit     held_dest;

   osd_regaccess_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .module_id (MODULE_ID),
      .in_link   (in_link),
      .in_ready  (in_ready),
      .out_link  (out_link),
      .out_ready (out_ready)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic load_trace();
      int          fd;
      int          c;
      int          n;
      logic [15:0] data;
      logic [3:0]  last;
      dii_flit     f;
      dii_flit     pkt[$];
      fd = $fopen("testbench/osd_regaccess_trace.txt", "r");
      if (fd == 0) begin
         abort_run("Could not open the trace file testbench/osd_regaccess_trace.txt");
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (c == "#") begin
            // Comment runs to the end of the line
            while (c != -1 && c != "\n") begin
               c = $fgetc(fd);
            end
         end else if (c == "I" || c == "O") begin
            n = $fscanf(fd, "%h %h", data, last);
            if (n != 2) begin
               abort_run("A flit record in the trace file could not be read");
            end
            f.data  = data;
            f.last  = last[0];
            f.valid = 1'b1;
            n_flits++;
            if (c == "I") begin
               stim_q.push_back(f);
            end else begin
               pkt.push_back(f);
               if (f.last) begin
                  if (pkt.size() < 3) begin
                     abort_run("An expected packet in the trace file is shorter than its header");
                  end
                  // Responses carry this module's address as their source
                  foreach (pkt[i]) begin
                     if (pkt[1].data == MODULE_ID) begin
                        exp_resp_q.push_back(pkt[i]);
                     end else begin
                        exp_byp_q.push_back(pkt[i]);
                     end
                  end
                  pkt.delete();
               end
            end
         end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
            abort_run("The trace file holds a record that is neither I nor O");
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   task automatic compare_flit(input dii_flit expected, input dii_flit actual);
      if (actual.data !== expected.data) begin
         abort_run($sformatf("CHECK FAILED out_link.data expected %04h actual %04h",
            expected.data, actual.data));
      end
      if (actual.last !== expected.last) begin
         abort_run($sformatf("CHECK FAILED out_link.last expected %h actual %h",
            expected.last, actual.last));
      end
   endtask

   task automatic match_stream_flit(input dii_flit actual);
      dii_flit expected;
      if (to_resp && exp_resp_q.size() == 0) begin
         abort_run("A response flit appeared on out_link with no response pending");
      end else if (!to_resp && exp_byp_q.size() == 0) begin
         abort_run("A bypass flit appeared on out_link with no bypass packet pending");
      end
      if (to_resp) begin
         expected = exp_resp_q.pop_front();
      end else begin
         expected = exp_byp_q.pop_front();
      end
      compare_flit(expected, actual);
   endtask

   task automatic check_out_flit(input dii_flit f);
      if (out_pos == 0) begin
         if (f.last) begin
            abort_run("An output packet ended on its destination flit");
         end
         held_dest = f;
      end else begin
         // Stream is known once the source flit shows up
         if (out_pos == 1) begin
            to_resp = (f.data == MODULE_ID);
            match_stream_flit(held_dest);
         end
         match_stream_flit(f);
      end
      out_pos = f.last ? 0 : out_pos + 1;
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // Random back-pressure, about one cycle in four
   always @(posedge clk) begin
      if (rst) begin
         out_ready <= 1'b0;
      end else begin
         out_ready <= ($urandom % 4) != 0;
      end
   end

   always @(posedge clk) begin
      if (!rst && out_link.valid && out_ready) begin
         check_out_flit(out_link);
      end
   end

   always @(posedge clk) begin
      if (!rst) begin
         cycles = cycles + 1;
         if (cycles > limit) begin
            abort_run("The output stalled and not all expected flits arrived in time");
         end
      end
   end

   initial begin
      rst       = 1'b1;
      in_link   = '0;
      out_ready = 1'b0;
      cycles    = 0;
      limit     = 0;
      void'($urandom(32'h2755));
      load_trace();
      limit = 40 * n_flits + 200;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Each flit is held until in_ready, with idle gaps now and then
      while (stim_q.size() > 0) begin
         if (($urandom % 4) == 0) begin
            in_link <= '0;
            @(posedge clk);
         end
         in_link <= stim_q.pop_front();
         @(posedge clk);
         while (!in_ready) begin
            @(posedge clk);
         end
      end
      in_link <= '0;

      while (exp_resp_q.size() + exp_byp_q.size() > 0) begin
         @(posedge clk);
      end
      // Quiet period to catch stray output
      repeat (20) @(posedge clk);
      if (out_pos == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         abort_run("An extra output packet started after all expected packets");
      end
   end

endmodule

/* testbench/osd_regaccess_trace.txt */
# Columns: I = flit driven on in_link, O = flit expected on out_link,
# then the data word in hex and the last flag
# Bypass packet of type 2
I 0007 0
I 0009 0
I 8000 0
I 1111 0
I 2222 1
O 0007 0
O 0009 0
O 8000 0
O 1111 0
O 2222 1
# Write BEEF to address 3
I 0005 0
I 0010 0
I 0800 0
I 0003 0
I BEEF 1
O 0010 0
O 0005 0
O 2800 1
# Read address 3
I 0005 0
I 0011 0
I 0000 0
I 0003 1
O 0011 0
O 0005 0
O 2000 0
O BEEF 1
# Read of unmapped address 9
I 0005 0
I 0012 0
I 0000 0
I 0009 1
O 0012 0
O 0005 0
O 2400 1
# Write to the read-only ID register
I 0005 0
I 0013 0
I 0800 0
I 0000 0
I 1234 1
O 0013 0
O 0005 0
O 2C00 1
# Unknown subtype 5, dropped
I 0005 0
I 0014 0
I 1400 0
I 0003 1
# Read without its address flit, dropped
I 0005 0
I 0015 0
I 0000 1
# Read of the ID register
I 0005 0
I 0016 0
I 0000 0
I 0000 1
O 0016 0
O 0005 0
O 2000 0
O 0A51 1
# Bypass packet of type 3 right behind a request
I 0030 0
I 0031 0
I C000 0
I 0DDD 1
O 0030 0
O 0031 0
O C000 0
O 0DDD 1
# Read address 3 again
I 0005 0
I 0017 0
I 0000 0
I 0003 1
O 0017 0
O 0005 0
O 2000 0
O BEEF 1

/* project.f */
+incdir+include
hdl/osd_pkg.sv
hdl/osd_reg_file.sv
hdl/osd_flit_counter.sv
hdl/osd_regaccess_demux.sv
hdl/osd_regaccess_fsm.sv
hdl/osd_out_arbiter.sv
hdl/osd_regaccess_top.sv
testbench/osd_regaccess_props.sv
testbench/osd_regaccess_tb.sv
